//--- Makefile
# Verilator build and run of the channel hub testbench

VERILATOR ?= verilator
TOP       ?= tb_chan_hub
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= TESTBENCH PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- common/chan_pkg.sv
// Shared widths, channel port numbers and buffer sizes for the packet channel hub
package chan_pkg;

	// --------------------
	// Stream geometry
	// --------------------
	localparam int CHAN_DATA_W = 8;  // Bytes on every stream
	localparam int CHAN_PORT_W = 4;  // Port address on the host side
	localparam int NUM_CHAN    = 3;  // Regs, digest, loopback
	localparam int CHAN_IDX_W  = $clog2(NUM_CHAN);

	// Loopback buffer
	localparam int LOOP_DEPTH = 16;
	localparam int LOOP_AW    = $clog2(LOOP_DEPTH);

	typedef logic [CHAN_DATA_W-1:0] chan_data_t;
	typedef logic [CHAN_IDX_W-1:0]  chan_idx_t;   // Arbiter slot, 0 is regs
	typedef logic [LOOP_AW-1:0]     loop_ptr_t;
	typedef logic [LOOP_AW:0]       loop_cnt_t;   // One extra bit for full

	// --------------------
	// Port numbers
	// --------------------
	// PORT_NONE marks a frame that goes nowhere and is dropped
	typedef enum logic [CHAN_PORT_W-1:0]
	{
		PORT_NONE   = 4'd0,
		PORT_REGS   = 4'd1,  // LEDs in, DIP out
		PORT_DIGEST = 4'd2,  // Count, sum, XOR
		PORT_LOOP   = 4'd3   // Echo
	} chan_id_e;

endpackage

//--- common/chan_stream_if.sv
// One 8-bit framed byte stream with the source-ready / destination-ready handshake
interface chan_stream_if;

	chan_pkg::chan_data_t data;
	logic                 sof;      // First beat of a frame
	logic                 eof;      // Last beat, may share the sof beat
	logic                 src_rdy;  // Source has a beat
	logic                 dst_rdy;  // Sink takes it

	// Producer side
	modport src
	(
		output data, sof, eof, src_rdy,
		input  dst_rdy
	);

	// Consumer side
	modport dst
	(
		input  data, sof, eof, src_rdy,
		output dst_rdy
	);

endinterface

//--- rtl/chan_demux.sv
// Ingress router, steers each host frame to the channel named on its first beat
module chan_demux
(
	input  logic                              clk_local,
	input  logic                              rst_local,
	input  chan_pkg::chan_data_t              rx_data,
	input  logic                              rx_sof,
	input  logic                              rx_eof,
	input  logic                              rx_src_rdy,
	input  logic [chan_pkg::CHAN_PORT_W-1:0]  rx_port,
	output logic                              rx_dst_rdy,
	chan_stream_if.src                        to_regs,
	chan_stream_if.src                        to_digest,
	chan_stream_if.src                        to_loop
);

	chan_pkg::chan_id_e sof_sel;   // Decoded from rx_port
	chan_pkg::chan_id_e sel_q;     // Held for the rest of the frame
	chan_pkg::chan_id_e cur_sel;
	logic               frame_open;
	logic               rx_xfer;

	// --------------------
	// Port decode
	// --------------------
	always_comb
	begin
		case (rx_port)
			4'd1:    sof_sel = chan_pkg::PORT_REGS;
			4'd2:    sof_sel = chan_pkg::PORT_DIGEST;
			4'd3:    sof_sel = chan_pkg::PORT_LOOP;
			default: sof_sel = chan_pkg::PORT_NONE;  // Swallowed
		endcase
	end

	assign cur_sel = rx_sof ? sof_sel : sel_q;  // Port only valid on sof
	assign rx_xfer = rx_src_rdy && rx_dst_rdy;

	// Payload fans out, only src_rdy is steered
	assign to_regs.data   = rx_data;
	assign to_regs.sof    = rx_sof;
	assign to_regs.eof    = rx_eof;
	assign to_digest.data = rx_data;
	assign to_digest.sof  = rx_sof;
	assign to_digest.eof  = rx_eof;
	assign to_loop.data   = rx_data;
	assign to_loop.sof    = rx_sof;
	assign to_loop.eof    = rx_eof;

	assign to_regs.src_rdy   = rx_src_rdy && (cur_sel == chan_pkg::PORT_REGS);
	assign to_digest.src_rdy = rx_src_rdy && (cur_sel == chan_pkg::PORT_DIGEST);
	assign to_loop.src_rdy   = rx_src_rdy && (cur_sel == chan_pkg::PORT_LOOP);

	always_comb
	begin
		case (cur_sel)
			chan_pkg::PORT_REGS:   rx_dst_rdy = to_regs.dst_rdy;
			chan_pkg::PORT_DIGEST: rx_dst_rdy = to_digest.dst_rdy;
			chan_pkg::PORT_LOOP:   rx_dst_rdy = to_loop.dst_rdy;
			default:               rx_dst_rdy = 1'b1;  // Drop at line rate
		endcase
	end

	// --------------------
	// Frame tracking
	// --------------------
	always_ff @(posedge clk_local)
	begin
		if (rst_local)
		begin
			sel_q      <= chan_pkg::PORT_NONE;
			frame_open <= 1'b0;
		end
		else if (rx_xfer)
		begin
			if (rx_sof)
				sel_q <= sof_sel;
			frame_open <= !rx_eof;  // One-beat frames never open
		end
	end

	// Host must close a frame before starting the next
	a_no_nested_sof: assert property (@(posedge clk_local) disable iff (rst_local)
		(rx_xfer && frame_open) |-> !rx_sof)
		else $error("sof beat inside an open frame");

endmodule

//--- rtl/chan_hub_top.sv
// Top of the channel hub, ties the ingress router, three channels and the return arbiter
module chan_hub_top
(
	input  logic                              clk_local,
	input  logic                              rst_local,

	// Host ingress
	input  chan_pkg::chan_data_t              rx_data,
	input  logic                              rx_sof,
	input  logic                              rx_eof,
	input  logic                              rx_src_rdy,
	input  logic [chan_pkg::CHAN_PORT_W-1:0]  rx_port,
	output logic                              rx_dst_rdy,

	// Host return
	output chan_pkg::chan_data_t              tx_data,
	output logic                              tx_sof,
	output logic                              tx_eof,
	output logic                              tx_src_rdy,
	output logic [chan_pkg::CHAN_PORT_W-1:0]  tx_port,
	input  logic                              tx_dst_rdy,

	// Board I/O
	input  chan_pkg::chan_data_t              dip,
	output chan_pkg::chan_data_t              leds
);

	// --------------------
	// Channel streams
	// --------------------
	chan_stream_if to_regs ();
	chan_stream_if to_digest ();
	chan_stream_if to_loop ();
	chan_stream_if from_regs ();
	chan_stream_if from_digest ();
	chan_stream_if from_loop ();

	chan_demux u_demux (
		.clk_local (clk_local),  .rst_local (rst_local),
		.rx_data   (rx_data),    .rx_sof    (rx_sof),
		.rx_eof    (rx_eof),     .rx_src_rdy(rx_src_rdy),
		.rx_port   (rx_port),    .rx_dst_rdy(rx_dst_rdy),
		.to_regs   (to_regs),    .to_digest (to_digest),
		.to_loop   (to_loop)
	);

	// Channel 1, LEDs and DIP
	port_regs u_regs (
		.clk_local(clk_local), .rst_local(rst_local),
		.rx(to_regs), .tx(from_regs), .dip(dip), .leds(leds)
	);

	port_digest u_digest (
		.clk_local(clk_local), .rst_local(rst_local), .rx(to_digest), .tx(from_digest)
	);

	port_loopback u_loop (
		.clk_local(clk_local), .rst_local(rst_local), .rx(to_loop), .tx(from_loop)
	);

	chan_return_arb u_arb (
		.clk_local  (clk_local),  .rst_local  (rst_local),
		.from_regs  (from_regs),  .from_digest(from_digest),
		.from_loop  (from_loop),
		.tx_data    (tx_data),    .tx_sof     (tx_sof),
		.tx_eof     (tx_eof),     .tx_src_rdy (tx_src_rdy),
		.tx_port    (tx_port),    .tx_dst_rdy (tx_dst_rdy)
	);

endmodule

//--- rtl/chan_return_arb.sv
// Frame-level round-robin merge of the three channel replies onto the host return stream
module chan_return_arb
(
	input  logic                              clk_local,
	input  logic                              rst_local,
	chan_stream_if.dst                        from_regs,
	chan_stream_if.dst                        from_digest,
	chan_stream_if.dst                        from_loop,
	output chan_pkg::chan_data_t              tx_data,
	output logic                              tx_sof,
	output logic                              tx_eof,
	output logic                              tx_src_rdy,
	output logic [chan_pkg::CHAN_PORT_W-1:0]  tx_port,
	input  logic                              tx_dst_rdy
);

	typedef enum logic {arb_idle, arb_busy} arb_state_e;

	arb_state_e                      state_q;
	chan_pkg::chan_idx_t             grant_q;    // Current owner of tx
	chan_pkg::chan_idx_t             last_q;     // Previous winner
	chan_pkg::chan_idx_t             pick_idx;
	logic                            pick_valid;
	logic [chan_pkg::NUM_CHAN-1:0]   req;
	logic                            sel_src_rdy;
	logic                            tx_xfer;
	chan_pkg::chan_idx_t             rr_idx;
	chan_pkg::chan_id_e              grant_id;

	assign req = {from_loop.src_rdy, from_digest.src_rdy, from_regs.src_rdy};

	// --------------------
	// Round-robin pick
	// --------------------
	always_comb
	begin
		pick_valid = 1'b0;
		pick_idx   = last_q;
		rr_idx     = '0;
		for (int i = 1; i <= chan_pkg::NUM_CHAN; i++)
		begin
			// Start after last winner
			rr_idx = chan_pkg::chan_idx_t'((int'(last_q) + i) % chan_pkg::NUM_CHAN);
			if (!pick_valid && req[rr_idx])
			begin
				pick_valid = 1'b1;
				pick_idx   = rr_idx;
			end
		end
	end

	// Output mux
	always_comb
	begin
		case (grant_q)
			2'd0:
			begin
				tx_data     = from_regs.data;
				tx_sof      = from_regs.sof;
				tx_eof      = from_regs.eof;
				sel_src_rdy = from_regs.src_rdy;
				grant_id    = chan_pkg::PORT_REGS;
			end
			2'd1:
			begin
				tx_data     = from_digest.data;
				tx_sof      = from_digest.sof;
				tx_eof      = from_digest.eof;
				sel_src_rdy = from_digest.src_rdy;
				grant_id    = chan_pkg::PORT_DIGEST;
			end
			default:
			begin
				tx_data     = from_loop.data;
				tx_sof      = from_loop.sof;
				tx_eof      = from_loop.eof;
				sel_src_rdy = from_loop.src_rdy;
				grant_id    = chan_pkg::PORT_LOOP;
			end
		endcase
	end

	assign tx_src_rdy = (state_q == arb_busy) && sel_src_rdy;
	assign tx_port    = grant_id;  // Tag with the source channel
	assign tx_xfer    = tx_src_rdy && tx_dst_rdy;

	// Stall reaches only the granted channel
	assign from_regs.dst_rdy   = (state_q == arb_busy) && (grant_q == 2'd0) && tx_dst_rdy;
	assign from_digest.dst_rdy = (state_q == arb_busy) && (grant_q == 2'd1) && tx_dst_rdy;
	assign from_loop.dst_rdy   = (state_q == arb_busy) && (grant_q == 2'd2) && tx_dst_rdy;

	// --------------------
	// Grant FSM
	// --------------------
	always_ff @(posedge clk_local)
	begin
		if (rst_local)
		begin
			state_q <= arb_idle;
			grant_q <= '0;
			last_q  <= chan_pkg::chan_idx_t'(chan_pkg::NUM_CHAN - 1);  // Regs first
		end
		else
		begin
			case (state_q)
				arb_idle:
					if (pick_valid)
					begin
						grant_q <= pick_idx;
						state_q <= arb_busy;
					end
				arb_busy:
					if (tx_xfer && tx_eof)  // Frame done so arbitration reopens
					begin
						last_q  <= grant_q;
						state_q <= arb_idle;
					end
				default: state_q <= arb_idle;
			endcase
		end
	end

	// A new grant always opens on a sof beat
	a_grant_on_sof: assert property (@(posedge clk_local) disable iff (rst_local)
		(state_q == arb_idle && pick_valid) |=> (tx_src_rdy && tx_sof))
		else $error("grant started inside a frame");

endmodule

//--- rtl/port_digest.sv
// Digest channel that accumulates byte count, sum and XOR of a frame and replies with three bytes
module port_digest
(
	input  logic       clk_local,
	input  logic       rst_local,
	chan_stream_if.dst rx,
	chan_stream_if.src tx
);

	typedef enum logic {collect, reply} digest_state_e;

	digest_state_e        state_q;
	chan_pkg::chan_data_t cnt_q;   // Wraps at 256
	chan_pkg::chan_data_t sum_q;
	chan_pkg::chan_data_t xor_q;
	logic [1:0]           beat_q;  // Reply beat 0..2
	logic                 rx_xfer;
	logic                 tx_xfer;

	assign rx.dst_rdy = (state_q == collect);
	assign rx_xfer    = rx.src_rdy && rx.dst_rdy;
	assign tx_xfer    = tx.src_rdy && tx.dst_rdy;

	// --------------------
	// Reply beats
	// --------------------
	always_comb
	begin
		case (beat_q)
			2'd0:    tx.data = cnt_q;
			2'd1:    tx.data = sum_q;
			default: tx.data = xor_q;
		endcase
	end

	assign tx.sof     = (beat_q == 2'd0);
	assign tx.eof     = (beat_q == 2'd2);
	assign tx.src_rdy = (state_q == reply);

	always_ff @(posedge clk_local)
	begin
		if (rst_local)
		begin
			state_q <= collect;
			cnt_q   <= '0;
			sum_q   <= '0;
			xor_q   <= '0;
			beat_q  <= '0;
		end
		else if (state_q == collect)
		begin
			if (rx_xfer)
			begin
				cnt_q <= cnt_q + 1'b1;
				sum_q <= sum_q + rx.data;
				xor_q <= xor_q ^ rx.data;
				if (rx.eof)
					state_q <= reply;  // Sums include the eof byte
			end
		end
		else if (tx_xfer)
		begin
			if (tx.eof)
			begin
				// Ready for the next frame
				cnt_q   <= '0;
				sum_q   <= '0;
				xor_q   <= '0;
				beat_q  <= '0;
				state_q <= collect;
			end
			else
				beat_q <= beat_q + 1'b1;
		end
	end

	// Every reply opens on the count beat
	a_reply_from_count: assert property (@(posedge clk_local) disable iff (rst_local)
		(state_q == collect) |-> (beat_q == 2'd0))
		else $error("reply beat counter not cleared between frames");

endmodule

//--- rtl/port_loopback.sv
// Loopback channel that buffers beats in a small FIFO and sends each frame back unchanged
module port_loopback
(
	input  logic       clk_local,
	input  logic       rst_local,
	chan_stream_if.dst rx,
	chan_stream_if.src tx
);

	// Entry is {sof, eof, data}
	logic [chan_pkg::CHAN_DATA_W+1:0] mem [chan_pkg::LOOP_DEPTH];
	logic [chan_pkg::CHAN_DATA_W+1:0] rd_word;

	chan_pkg::loop_ptr_t wr_ptr;
	chan_pkg::loop_ptr_t rd_ptr;
	chan_pkg::loop_cnt_t count;
	logic                full;
	logic                empty;
	logic                wr_en;
	logic                rd_en;

	assign full  = (count == chan_pkg::loop_cnt_t'(chan_pkg::LOOP_DEPTH));
	assign empty = (count == '0);

	assign rx.dst_rdy = !full;  // Back-pressure only at full
	assign wr_en      = rx.src_rdy && rx.dst_rdy;
	assign rd_en      = tx.src_rdy && tx.dst_rdy;

	// --------------------
	// Storage
	// --------------------
	always_ff @(posedge clk_local)
	begin
		if (wr_en)
			mem[wr_ptr] <= {rx.sof, rx.eof, rx.data};
	end

	// Head of FIFO straight to the output
	assign rd_word    = mem[rd_ptr];
	assign tx.sof     = rd_word[chan_pkg::CHAN_DATA_W+1];
	assign tx.eof     = rd_word[chan_pkg::CHAN_DATA_W];
	assign tx.data    = rd_word[chan_pkg::CHAN_DATA_W-1:0];
	assign tx.src_rdy = !empty;

	// Pointers and occupancy
	always_ff @(posedge clk_local)
	begin
		if (rst_local)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;  // Wraps at the power of two depth
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;
			case ({wr_en, rd_en})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Occupancy tracks the distance between the pointers
	a_count_tracks_ptrs: assert property (@(posedge clk_local) disable iff (rst_local)
		count[chan_pkg::LOOP_AW-1:0] == chan_pkg::loop_ptr_t'(wr_ptr - rd_ptr))
		else $error("loopback count and pointers disagree");

endmodule

//--- rtl/port_regs.sv
// Register channel, loads the LEDs from a host frame and answers with the DIP switches
module port_regs
(
	input  logic                 clk_local,
	input  logic                 rst_local,
	chan_stream_if.dst           rx,
	chan_stream_if.src           tx,
	input  chan_pkg::chan_data_t dip,
	output chan_pkg::chan_data_t leds
);

	chan_pkg::chan_data_t dip_q;       // Sampled switches
	logic                 reply_pend;  // One-beat answer waiting

	// Busy until the answer is gone
	assign rx.dst_rdy = !reply_pend;

	assign tx.data    = dip_q;
	assign tx.sof     = 1'b1;  // Single beat reply
	assign tx.eof     = 1'b1;
	assign tx.src_rdy = reply_pend;

	always_ff @(posedge clk_local)
	begin
		dip_q <= dip;
	end

	// --------------------
	// LED load and reply
	// --------------------
	always_ff @(posedge clk_local)
	begin
		if (rst_local)
		begin
			leds       <= '0;
			reply_pend <= 1'b0;
		end
		else
		begin
			if (rx.src_rdy && rx.dst_rdy && rx.eof)  // Last byte wins
			begin
				leds       <= rx.data;
				reply_pend <= 1'b1;
			end
			else if (tx.src_rdy && tx.dst_rdy)
				reply_pend <= 1'b0;
		end
	end

endmodule

//--- sources.f
common/chan_pkg.sv
common/chan_stream_if.sv
rtl/chan_demux.sv
rtl/port_regs.sv
rtl/port_digest.sv
rtl/port_loopback.sv
rtl/chan_return_arb.sv
rtl/chan_hub_top.sv
tb/tb_chan_hub.sv

//--- tb/tb_chan_hub.sv
// Self-checking testbench that sends random frames to the channel hub and checks replies per port
module tb_chan_hub;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_FRAMES  = 200;
	localparam int WATCHDOG_NS = NUM_FRAMES * 40 * 20 * 4;  // Frames x beats x period x margin

	logic                                clk_local;
	logic                                rst_local;
	logic [chan_pkg::CHAN_DATA_W-1:0]    rx_data;
	logic                                rx_sof;
	logic                                rx_eof;
	logic                                rx_src_rdy;
	logic [chan_pkg::CHAN_PORT_W-1:0]    rx_port;
	logic                                rx_dst_rdy;
	logic [chan_pkg::CHAN_DATA_W-1:0]    tx_data;
	logic                                tx_sof;
	logic                                tx_eof;
	logic                                tx_src_rdy;
	logic [chan_pkg::CHAN_PORT_W-1:0]    tx_port;
	logic                                tx_dst_rdy;
	logic [chan_pkg::CHAN_DATA_W-1:0]    dip;
	logic [chan_pkg::CHAN_DATA_W-1:0]    leds;

	// --------------------
	// Reply model
	// --------------------
	logic [7:0] regs_q[$];      // DIP expected per port 1 frame
	logic [7:0] leds_q[$];      // Last byte per port 1 frame
	logic [7:0] digest_q[$];    // Count, sum, XOR
	logic [7:0] loop_q[$];      // Echo bytes
	int         loop_len_q[$];  // Echo frame lengths

	int         value_errors;
	int         other_errors;
	int         frames_seen;
	logic       frame_open;     // Return frame in progress
	logic [3:0] open_port;
	int         beat_idx;

	chan_hub_top chan_hub_top_i (
		.clk_local (clk_local),  .rst_local (rst_local),
		.rx_data   (rx_data),    .rx_sof    (rx_sof),
		.rx_eof    (rx_eof),     .rx_src_rdy(rx_src_rdy),
		.rx_port   (rx_port),    .rx_dst_rdy(rx_dst_rdy),
		.tx_data   (tx_data),    .tx_sof    (tx_sof),
		.tx_eof    (tx_eof),     .tx_src_rdy(tx_src_rdy),
		.tx_port   (tx_port),    .tx_dst_rdy(tx_dst_rdy),
		.dip       (dip),        .leds      (leds)
	);

	always #10 clk_local = ~clk_local;  // 20 ns period

	// Host return back-pressure with ready about 70 percent
	always @(negedge clk_local)
		tx_dst_rdy <= ($urandom_range(0, 9) < 7);

	// --------------------
	// Ingress driver
	// --------------------
	task automatic send_frame(input logic [3:0] port, input int len);
		logic [7:0] bytes[$];
		logic [7:0] sum;
		logic [7:0] xsum;
		logic [7:0] b;
		int         i;
		sum  = 8'h00;
		xsum = 8'h00;
		for (i = 0; i < len; i++)
		begin
			b = 8'($urandom_range(0, 255));
			bytes.push_back(b);
			sum  = sum + b;   // Wraps at 256
			xsum = xsum ^ b;
		end
		// Expected replies go in before the frame leaves
		case (port)
			chan_pkg::PORT_REGS:
			begin
				regs_q.push_back(dip);
				leds_q.push_back(bytes[len-1]);
			end
			chan_pkg::PORT_DIGEST:
			begin
				digest_q.push_back(8'(len));
				digest_q.push_back(sum);
				digest_q.push_back(xsum);
			end
			chan_pkg::PORT_LOOP:
			begin
				foreach (bytes[k])
					loop_q.push_back(bytes[k]);
				loop_len_q.push_back(len);
			end
			default: ;  // Port 4 is dropped
		endcase
		for (i = 0; i < len; i++)
		begin
			rx_data    = bytes[i];
			rx_sof     = (i == 0);
			rx_eof     = (i == len - 1);
			rx_port    = port;
			rx_src_rdy = 1'b1;
			do
				@(posedge clk_local);
			while (!rx_dst_rdy);  // Held until the beat transfers
			@(negedge clk_local);
			rx_src_rdy = 1'b0;
			if (i != len - 1 && $urandom_range(0, 4) == 0)
				repeat ($urandom_range(1, 2)) @(negedge clk_local);  // Gap inside frame
		end
		rx_sof = 1'b0;
		rx_eof = 1'b0;
	endtask

	// --------------------
	// Return monitor
	// --------------------
	task automatic check_beat();
		logic [7:0] exp;
		logic [7:0] exp_leds;
		logic       exp_eof;
		exp_eof = 1'b1;
		if (tx_sof)
		begin
			assert (!frame_open) else
			begin
				other_errors++;
				$display("At %0t ns a return frame started inside an open frame", $time);
			end
			frame_open = 1'b1;
			open_port  = tx_port;
			beat_idx   = 0;
		end
		else
		begin
			assert (frame_open) else
			begin
				other_errors++;
				$display("At %0t ns a return beat came without a start of frame", $time);
			end
			assert (tx_port == open_port) else
			begin
				value_errors++;
				$display("[FAIL] %0t ns tx_port expected %0d got %0d",
					$time, open_port, tx_port);
			end
		end
		case (tx_port)
			chan_pkg::PORT_REGS:
				if (regs_q.size() == 0)
				begin
					other_errors++;
					$display("At %0t ns an unexpected frame came back from port 1", $time);
				end
				else
				begin
					exp      = regs_q.pop_front();
					exp_leds = leds_q.pop_front();
					assert (tx_data == exp) else
					begin
						value_errors++;
						$display("[FAIL] %0t ns tx_data expected %02h got %02h",
							$time, exp, tx_data);
					end
					assert (leds == exp_leds) else
					begin
						value_errors++;
						$display("[FAIL] %0t ns leds expected %02h got %02h",
							$time, exp_leds, leds);
					end
				end
			chan_pkg::PORT_DIGEST:
				if (digest_q.size() == 0)
				begin
					other_errors++;
					$display("At %0t ns an unexpected frame came back from port 2", $time);
				end
				else
				begin
					exp     = digest_q.pop_front();
					exp_eof = (beat_idx == 2);  // Count, sum, XOR
					assert (tx_data == exp) else
					begin
						value_errors++;
						$display("[FAIL] %0t ns tx_data expected %02h got %02h",
							$time, exp, tx_data);
					end
				end
			chan_pkg::PORT_LOOP:
				if (loop_q.size() == 0 || loop_len_q.size() == 0)
				begin
					other_errors++;
					$display("At %0t ns an unexpected frame came back from port 3", $time);
				end
				else
				begin
					exp     = loop_q.pop_front();
					exp_eof = (beat_idx == loop_len_q[0] - 1);
					if (exp_eof)
						void'(loop_len_q.pop_front());
					assert (tx_data == exp) else
					begin
						value_errors++;
						$display("[FAIL] %0t ns tx_data expected %02h got %02h",
							$time, exp, tx_data);
					end
				end
			default:
			begin
				other_errors++;
				$display("At %0t ns a frame came back tagged with unknown port %0d",
					$time, tx_port);
			end
		endcase
		assert (tx_eof == exp_eof) else
		begin
			value_errors++;
			$display("[FAIL] %0t ns tx_eof expected %0b got %0b", $time, exp_eof, tx_eof);
		end
		if (tx_eof)
		begin
			frame_open = 1'b0;
			frames_seen++;
		end
		beat_idx++;
	endtask

	// Sampled before the DUT registers update
	always @(posedge clk_local)
	begin
		if (!rst_local && tx_src_rdy && tx_dst_rdy)
			check_beat();
	end

	// Watchdog
	initial
	begin
		#(WATCHDOG_NS);
		$display("Run timed out after %0d ns with replies still outstanding", WATCHDOG_NS);
		$display("TESTBENCH FAILED");
		$finish;
	end

	// --------------------
	// Main sequence
	// --------------------
	initial
	begin
		int port;
		int len;
		int n;
		void'($urandom(26170));
		$timeformat(-9, 0, "", 0);
		clk_local    = 1'b0;
		rst_local    = 1'b1;
		rx_data      = '0;
		rx_sof       = 1'b0;
		rx_eof       = 1'b0;
		rx_src_rdy   = 1'b0;
		rx_port      = '0;
		tx_dst_rdy   = 1'b0;
		dip          = '0;
		value_errors = 0;
		other_errors = 0;
		frames_seen  = 0;
		frame_open   = 1'b0;
		open_port    = '0;
		beat_idx     = 0;
		repeat (16) @(posedge clk_local);
		@(negedge clk_local);
		rst_local = 1'b0;
		assert (tx_src_rdy == 1'b0) else
		begin
			value_errors++;
			$display("[FAIL] %0t ns tx_src_rdy expected 0 got %0b", $time, tx_src_rdy);
		end
		assert (leds == 8'h00) else
		begin
			value_errors++;
			$display("[FAIL] %0t ns leds expected 00 got %02h", $time, leds);
		end
		assert (rx_dst_rdy == 1'b1) else
		begin
			value_errors++;
			$display("[FAIL] %0t ns rx_dst_rdy expected 1 got %0b", $time, rx_dst_rdy);
		end
		for (n = 0; n < NUM_FRAMES; n++)
		begin
			port = $urandom_range(1, 4);
			len  = $urandom_range(1, 20);
			if (regs_q.size() == 0 && $urandom_range(0, 3) == 0)
				dip = 8'($urandom_range(0, 255));  // No register reply outstanding
			send_frame(4'(port), len);
			repeat ($urandom_range(0, 4)) @(negedge clk_local);
		end
		// Drain and then watch for strays
		while (regs_q.size() + digest_q.size() + loop_q.size() != 0)
			@(negedge clk_local);
		repeat (100) @(negedge clk_local);
		assert (!frame_open && loop_len_q.size() == 0) else
		begin
			other_errors++;
			$display("A return frame was still open at the end of the run");
		end
		$display("Frames returned %0d, value errors %0d, other errors %0d",
			frames_seen, value_errors, other_errors);
		if (value_errors + other_errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule
